// ==== hdl/walkPkg.sv ====
package walkPkg;

	typedef enum logic [1:0] {
		dirUp    = 2'd0,
		dirRight = 2'd1,
		dirDown  = 2'd2,
		dirLeft  = 2'd3
	} dirT;

	// Rest phases share one sprite column
	typedef enum logic [1:0] {rest1, move1, rest2, move2} poseT;

	typedef enum logic [1:0] {reqStop, reqTurn, reqStep} reqKindT;

	// Sprite sheet column offset for a direction and a pose
	function automatic logic [7:0] spriteBaseFn(dirT d, poseT p);
		logic [7:0] base;
		case (d)
			dirDown:  base = 8'd0;
			dirLeft:  base = 8'd57;
			dirUp:    base = 8'd114;
			default:  base = 8'd171;
		endcase
		case (p)
			move1:   return base;
			move2:   return base + 8'd38;
			default: return base + 8'd19;
		endcase
	endfunction

	// Collision status bit blocking each direction
	function automatic logic [1:0] collBit(dirT d);
		case (d)
			dirUp:    return 2'd3;
			dirRight: return 2'd0;
			dirDown:  return 2'd1;
			default:  return 2'd2;
		endcase
	endfunction

endpackage

// ==== hdl/screenPkg.sv ====
package screenPkg;

	typedef logic [10:0] coordT;
	typedef logic signed [12:0] camT;
	typedef logic [12:0] spriteAddrT;
	typedef logic [18:0] mapAddrT;

	// Character window on screen
	localparam int CharX0 = 311;
	localparam int CharY0 = 340;
	localparam int CharW = 19;
	localparam int CharH = 29;

	// Sprite sheet row width in pixels
	localparam int SheetStride = 228;

	// Map cells are 4x4 pixels
	localparam int TileShift = 2;
	localparam int MapH = 240;

	localparam int StartX = 100;
	localparam int StartY = 100;

	// Camera limits checked before each move
	localparam int CamUpLimit = -340;
	localparam int CamRightLimit = 951;
	localparam int CamDownLimit = 594;
	localparam int CamLeftLimit = -311;

endpackage

// ==== hdl/moveReqIf.sv ====
`timescale 1ns/1ps

interface moveReqIf;
	import walkPkg::*;

	logic reqValid;
	reqKindT reqKind;
	dirT reqDir;
	// Current facing fed back for turn detection
	dirT facing;

	modport decoder (
		output reqValid, reqKind, reqDir,
		input facing
	);

	modport controller (
		input reqValid, reqKind, reqDir,
		output facing
	);

endinterface

// ==== hdl/viewIf.sv ====
`timescale 1ns/1ps

interface viewIf;
	import walkPkg::*;
	import screenPkg::*;

	camT camX;
	camT camY;
	dirT facing;
	poseT pose;

	modport source (
		output camX, camY, facing, pose
	);

	modport sink (
		input camX, camY, facing, pose
	);

endinterface

// ==== hdl/moveDecoder.sv ====
`timescale 1ns/1ps

module moveDecoder (
	input logic Clk,
	input logic rstN,
	input logic frameTick,
	input logic moving,
	input walkPkg::dirT dir,
	moveReqIf.decoder req
);
	import walkPkg::*;

	reqKindT kindNext;

	always_comb begin
		if (!moving) begin
			kindNext = reqStop;
		end else if (dir != req.facing) begin
			kindNext = reqTurn;
		end else begin
			kindNext = reqStep;
		end
	end

	always_ff @(posedge Clk or negedge rstN) begin
		if (!rstN) begin
			req.reqValid <= 1'b0;
		end else begin
			req.reqValid <= frameTick;
		end
	end

	// Request payload sampled on the tick
	always_ff @(posedge Clk) begin
		if (frameTick) begin
			req.reqKind <= kindNext;
			req.reqDir <= dir;
		end
	end

	// One request per frame tick
	assert property (@(posedge Clk) disable iff (!rstN)
		req.reqValid |=> !req.reqValid);

endmodule

// ==== hdl/walkController.sv ====
`timescale 1ns/1ps

module walkController #(
	parameter int MapW = 320,
	parameter int StepDelay = 8
) (
	input logic Clk,
	input logic rstN,
	moveReqIf.controller req,
	input logic [3:0] collStatus,
	viewIf.source view,
	output screenPkg::mapAddrT collAddr
);
	import walkPkg::*;
	import screenPkg::*;

	localparam int CntW = (StepDelay > 1) ? $clog2(StepDelay) : 1;

	camT camX;
	camT camY;
	dirT facing;
	poseT pose;
	logic [CntW-1:0] delayCnt;

	logic signed [12:0] charWorldX;
	logic signed [12:0] charWorldY;
	logic [10:0] charCol;
	logic [10:0] charRow;

	always_ff @(posedge Clk or negedge rstN) begin
		if (!rstN) begin
			camX <= camT'(StartX);
			camY <= camT'(StartY);
			facing <= dirDown;
			pose <= rest1;
			delayCnt <= '0;
		end else if (req.reqValid) begin
			case (req.reqKind)
				reqStop: begin
					pose <= rest1;
				end
				reqTurn: begin
					facing <= req.reqDir;
					pose <= rest1;
				end
				reqStep: begin
					// Animation only advances when the delay counter wraps
					if (delayCnt == '0) begin
						pose <= poseT'(pose + 2'd1);
					end
					if (delayCnt == CntW'(StepDelay - 1)) begin
						delayCnt <= '0;
					end else begin
						delayCnt <= delayCnt + 1'b1;
					end
					if (!collStatus[collBit(facing)]) begin
						case (facing)
							dirUp: begin
								if (camY > CamUpLimit) begin
									camY <= camY - 13'sd1;
								end
							end
							dirRight: begin
								if (camX <= CamRightLimit) begin
									camX <= camX + 13'sd1;
								end
							end
							dirDown: begin
								if (camY <= CamDownLimit) begin
									camY <= camY + 13'sd1;
								end
							end
							default: begin
								if (camX > CamLeftLimit) begin
									camX <= camX - 13'sd1;
								end
							end
						endcase
					end
				end
				default: ;
			endcase
		end
	end

	// Map cell under the character origin
	always_comb begin
		charWorldX = camX + 13'sd311;
		charWorldY = camY + 13'sd340;
		charCol = 11'(charWorldX >>> TileShift);
		charRow = 11'(charWorldY >>> TileShift);
		collAddr = mapAddrT'(charRow * MapW + charCol);
	end

	assign req.facing = facing;
	assign view.camX = camX;
	assign view.camY = camY;
	assign view.facing = facing;
	assign view.pose = pose;

	// Camera stays one step past the move limits at most
	assert property (@(posedge Clk) disable iff (!rstN)
		camY >= CamUpLimit && camY <= CamDownLimit + 1 &&
		camX >= CamLeftLimit && camX <= CamRightLimit + 1);

endmodule

// ==== hdl/pixelAddresser.sv ====
`timescale 1ns/1ps

module pixelAddresser #(
	parameter int MapW = 320
) (
	input logic Clk,
	input logic rstN,
	input screenPkg::coordT drawX,
	input screenPkg::coordT drawY,
	viewIf.sink view,
	output screenPkg::spriteAddrT spriteAddr,
	output screenPkg::mapAddrT mapAddr,
	output logic characterHere,
	output logic mapValid
);
	import walkPkg::*;
	import screenPkg::*;

	logic signed [13:0] worldX;
	logic signed [13:0] worldY;
	logic worldNeg;
	logic [11:0] cellX;
	logic [11:0] cellY;
	logic inWindow;
	logic [10:0] winX;
	logic [10:0] winY;
	spriteAddrT spriteNext;
	mapAddrT mapNext;
	logic mapValidNext;

	// World position of the pixel
	always_comb begin
		worldX = $signed({3'b000, drawX}) + view.camX;
		worldY = $signed({3'b000, drawY}) + view.camY;
		worldNeg = worldX < 0 || worldY < 0;
		cellX = 12'(worldX >>> TileShift);
		cellY = 12'(worldY >>> TileShift);
		if (worldNeg) begin
			mapNext = '0;
			mapValidNext = 1'b0;
		end else begin
			mapNext = mapAddrT'(cellY * MapW + cellX);
			mapValidNext = cellX < MapW && cellY < MapH;
		end
	end

	// Character sprite window
	always_comb begin
		inWindow = drawX >= CharX0 && drawX < CharX0 + CharW &&
			drawY >= CharY0 && drawY < CharY0 + CharH;
		winX = drawX - 11'(CharX0);
		winY = drawY - 11'(CharY0);
		if (inWindow) begin
			spriteNext = spriteAddrT'(SheetStride * winY + winX +
				spriteBaseFn(view.facing, view.pose));
		end else begin
			spriteNext = '0;
		end
	end

	always_ff @(posedge Clk or negedge rstN) begin
		if (!rstN) begin
			spriteAddr <= '0;
			mapAddr <= '0;
			characterHere <= 1'b0;
			mapValid <= 1'b0;
		end else begin
			spriteAddr <= spriteNext;
			mapAddr <= mapNext;
			characterHere <= inWindow;
			mapValid <= mapValidNext;
		end
	end

endmodule

// ==== hdl/overworldWalker.sv ====
`timescale 1ns/1ps

module overworldWalker #(
	parameter int MapW = 320,
	parameter int StepDelay = 8
) (
	input logic Clk,
	input logic rstN,
	input logic frameTick,
	input logic moving,
	input walkPkg::dirT dir,
	input logic [3:0] collStatus,
	input screenPkg::coordT drawX,
	input screenPkg::coordT drawY,
	output screenPkg::spriteAddrT spriteAddr,
	output screenPkg::mapAddrT mapAddr,
	output logic characterHere,
	output logic mapValid,
	output screenPkg::mapAddrT collAddr
);

	moveReqIf moveReqBus ();
	viewIf viewBus ();

	moveDecoder i_moveDecoder (
		.Clk(Clk),
		.rstN(rstN),
		.frameTick(frameTick),
		.moving(moving),
		.dir(dir),
		.req(moveReqBus.decoder)
	);

	walkController #(
		.MapW(MapW),
		.StepDelay(StepDelay)
	) i_walkController (
		.Clk(Clk),
		.rstN(rstN),
		.req(moveReqBus.controller),
		.collStatus(collStatus),
		.view(viewBus.source),
		.collAddr(collAddr)
	);

	pixelAddresser #(
		.MapW(MapW)
	) i_pixelAddresser (
		.Clk(Clk),
		.rstN(rstN),
		.drawX(drawX),
		.drawY(drawY),
		.view(viewBus.sink),
		.spriteAddr(spriteAddr),
		.mapAddr(mapAddr),
		.characterHere(characterHere),
		.mapValid(mapValid)
	);

endmodule

// ==== verification/walkerTb.sv ====
`timescale 1ns/1ps

module walkerTb;
	import walkPkg::*;
	import screenPkg::*;

	localparam int MapW = 320;
	localparam int StepDelay = 8;

	typedef struct {
		logic moving;
		dirT dir;
		logic [3:0] coll;
		int expOffset;
	} frameT;

	logic Clk;
	logic rstN;
	logic frameTick;
	logic moving;
	dirT dir;
	logic [3:0] collStatus;
	coordT drawX;
	coordT drawY;
	spriteAddrT spriteAddr;
	mapAddrT mapAddr;
	logic characterHere;
	logic mapValid;
	mapAddrT collAddr;

	frameT frames[$];
	integer seed;
	int errors;
	int checks;

	// Reference model state
	int mCamX;
	int mCamY;
	int mFacing;
	int mPose;
	int mCnt;

	overworldWalker #(
		.MapW(MapW),
		.StepDelay(StepDelay)
	) i_dut (
		.Clk(Clk),
		.rstN(rstN),
		.frameTick(frameTick),
		.moving(moving),
		.dir(dir),
		.collStatus(collStatus),
		.drawX(drawX),
		.drawY(drawY),
		.spriteAddr(spriteAddr),
		.mapAddr(mapAddr),
		.characterHere(characterHere),
		.mapValid(mapValid),
		.collAddr(collAddr)
	);

	always #20 Clk = ~Clk;

	// Pose order rest1, move1, rest2, move2
	function automatic int spriteOffset(input int d, input int p);
		int base;
		case (d)
			0: base = 114;
			1: base = 171;
			2: base = 0;
			default: base = 57;
		endcase
		if (p == 1) begin
			return base;
		end else if (p == 3) begin
			return base + 38;
		end
		return base + 19;
	endfunction

	function automatic int collIndex(input int d);
		case (d)
			0: return 3;
			1: return 0;
			2: return 1;
			default: return 2;
		endcase
	endfunction

	function automatic int expectedCollAddr();
		return ((mCamY + 340) / 4) * MapW + (mCamX + 311) / 4;
	endfunction

	task automatic checkValue(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Fail at %0t: %s expected %0d got %0d", $time, name, exp, got);
		end
	endtask

	task automatic waitCycles(input int n);
		int i;
		for (i = 0; i < n; i++) begin
			@(negedge Clk);
		end
	endtask

	task automatic waitForStart(input int limit);
		int cycles;
		cycles = 0;
		while (collAddr !== expectedCollAddr() && cycles < limit) begin
			@(negedge Clk);
			cycles++;
		end
		if (collAddr !== expectedCollAddr()) begin
			errors++;
			$display("collAddr did not reach the start cell within %0d cycles", limit);
		end
	endtask

	task automatic addFrames(input logic mv, input dirT d, input logic [3:0] coll,
		input int n, input int lastOffset);
		frameT f;
		int i;
		for (i = 0; i < n; i++) begin
			f.moving = mv;
			f.dir = d;
			f.coll = coll;
			f.expOffset = (i == n - 1) ? lastOffset : -1;
			frames.push_back(f);
		end
	endtask

	// Output appears one cycle after the pixel is driven
	task automatic checkPixel(input int x, input int y);
		int wx;
		int wy;
		int expMap;
		int expSprite;
		logic expValid;
		logic expHere;
		drawX = coordT'(x);
		drawY = coordT'(y);
		wx = x + mCamX;
		wy = y + mCamY;
		if (wx < 0 || wy < 0) begin
			expMap = 0;
			expValid = 1'b0;
		end else begin
			expMap = (wy / 4) * MapW + wx / 4;
			expValid = (wx / 4 < MapW) && (wy / 4 < 240);
		end
		expHere = x >= CharX0 && x < CharX0 + CharW && y >= CharY0 && y < CharY0 + CharH;
		expSprite = 0;
		if (expHere) begin
			expSprite = SheetStride * (y - CharY0) + (x - CharX0) +
				spriteOffset(mFacing, mPose);
		end
		@(negedge Clk);
		checkValue("mapAddr", mapAddr, expMap);
		checkValue("mapValid", mapValid, expValid);
		checkValue("characterHere", characterHere, expHere);
		checkValue("spriteAddr", spriteAddr, expSprite);
	endtask

	task automatic updateModel(input frameT f);
		int d;
		d = int'(f.dir);
		if (!f.moving) begin
			mPose = 0;
		end else if (d != mFacing) begin
			mFacing = d;
			mPose = 0;
		end else begin
			if (mCnt == 0) begin
				mPose = (mPose + 1) % 4;
			end
			mCnt = (mCnt + 1) % StepDelay;
			if (!f.coll[collIndex(mFacing)]) begin
				// Camera bounds checked before the move
				case (mFacing)
					0: begin
						if (mCamY > -340) begin
							mCamY--;
						end
					end
					1: begin
						if (mCamX <= 951) begin
							mCamX++;
						end
					end
					2: begin
						if (mCamY <= 594) begin
							mCamY++;
						end
					end
					default: begin
						if (mCamX > -311) begin
							mCamX--;
						end
					end
				endcase
			end
		end
	endtask

	task automatic runFrame(input frameT f);
		moving = f.moving;
		dir = f.dir;
		collStatus = f.coll;
		frameTick = 1'b1;
		@(negedge Clk);
		frameTick = 1'b0;
		waitCycles(3);
		updateModel(f);
	endtask

	initial begin
		Clk = 1'b0;
		rstN = 1'b0;
		frameTick = 1'b0;
		moving = 1'b0;
		dir = dirDown;
		collStatus = 4'b0000;
		drawX = '0;
		drawY = '0;
		seed = 32'h0bd013ab;
		errors = 0;
		checks = 0;
		mCamX = 100;
		mCamY = 100;
		mFacing = 2;
		mPose = 0;
		mCnt = 0;

		// Right walk with offsets 190 171 190 209
		addFrames(1'b1, dirRight, 4'b0000, 1, 190);
		addFrames(1'b1, dirRight, 4'b0000, 1, 171);
		addFrames(1'b1, dirRight, 4'b0000, 7, 171);
		addFrames(1'b1, dirRight, 4'b0000, 1, 190);
		addFrames(1'b1, dirRight, 4'b0000, 7, 190);
		addFrames(1'b1, dirRight, 4'b0000, 1, 209);
		addFrames(1'b1, dirLeft, 4'b0000, 1, 76);
		addFrames(1'b1, dirLeft, 4'b0000, 8, 57);
		addFrames(1'b0, dirLeft, 4'b0000, 1, 76);
		// Left blocked while the animation still runs
		addFrames(1'b1, dirLeft, 4'b0100, 8, 57);
		addFrames(1'b1, dirLeft, 4'b1011, 1, 57);
		addFrames(1'b1, dirUp, 4'b0000, 1, 133);
		addFrames(1'b1, dirUp, 4'b1000, 1, 133);
		// Past the upper bound
		addFrames(1'b1, dirUp, 4'b0000, 450, -1);

		waitCycles(2);
		rstN = 1'b1;
		waitForStart(10);
		checkPixel(CharX0, CharY0);
		checkValue("spriteAddr", spriteAddr, 19);
		checkPixel(CharX0 + 5, CharY0 + 7);

		for (int i = 0; i < frames.size(); i++) begin
			runFrame(frames[i]);
			checkValue("collAddr", collAddr, expectedCollAddr());
			checkPixel(400, 300);
			// World cells beyond the map width and height
			checkPixel(1500, 300);
			checkPixel(400, 900);
			checkPixel(CharX0 + $unsigned($random(seed)) % CharW,
				CharY0 + $unsigned($random(seed)) % CharH);
			checkPixel($unsigned($random(seed)) % 800, $unsigned($random(seed)) % 600);
			if (frames[i].expOffset >= 0) begin
				checkPixel(CharX0, CharY0);
				checkValue("spriteAddr", spriteAddr, frames[i].expOffset);
			end
		end

		// Camera pinned at the top so the world row is negative
		checkValue("collAddr", collAddr, 104);
		checkPixel(10, 10);
		checkValue("mapValid", mapValid, 0);
		checkValue("mapAddr", mapAddr, 0);

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

// ==== list.f ====
hdl/walkPkg.sv
hdl/screenPkg.sv
hdl/moveReqIf.sv
hdl/viewIf.sv
hdl/moveDecoder.sv
hdl/walkController.sv
hdl/pixelAddresser.sv
hdl/overworldWalker.sv
verification/walkerTb.sv
